// ==== common/cpuPkg.sv ====
/* ISA types and constants for the 16-bit pipelined CPU. The ISA fixes all widths.
   Opcodes 13 and 15 are reserved and execute as NOP */
package cpuPkg;

  typedef logic [15:0] wordT;
  typedef logic [2:0]  regIndexT;

  // --------------------
  // Opcodes and ALU ops

  typedef enum logic [3:0] {
    opAdd  = 4'd0,
    opSub  = 4'd1,
    opAnd  = 4'd2,
    opOr   = 4'd3,
    opAddi = 4'd4,
    opSubi = 4'd5,
    opAndi = 4'd6,
    opOri  = 4'd7,
    opSt   = 4'd8,
    opLd   = 4'd9,
    opCbz  = 4'd10,
    opCbnz = 4'd11,
    opBu   = 4'd12,   // Unconditional branch B
    opNop  = 4'd14
  } Opcode;

  // Add to Or share encoding with the low opcode bits
  typedef enum logic [2:0] {
    aluAdd  = 3'd0,
    aluSub  = 3'd1,
    aluAnd  = 3'd2,
    aluOr   = 3'd3,
    aluPass = 3'd4
  } AluOp;

  // --------------------
  // Instruction and control words

  typedef struct packed {
    Opcode       op;
    logic [11:0] fields;   // Registers, immediate or branch offset
  } InstrWord;

  typedef struct packed {
    logic regWrite;
    logic memRead;
    logic memWrite;
    logic writeFromMem;      // Writeback takes load data
    logic useImm;            // Operand B is the immediate
    logic branchCond;
    logic branchOnNonZero;   // CBNZ
    logic branchUncond;
    AluOp aluOp;
  } CtrlWord;

  localparam CtrlWord ctrlIdle = '{
    regWrite:        1'b0,
    memRead:         1'b0,
    memWrite:        1'b0,
    writeFromMem:    1'b0,
    useImm:          1'b0,
    branchCond:      1'b0,
    branchOnNonZero: 1'b0,
    branchUncond:    1'b0,
    aluOp:           aluPass
  };

  localparam regIndexT zeroReg  = 3'd7;
  localparam wordT     pcStep   = 16'd2;
  localparam InstrWord nopInstr = '{op: opNop, fields: 12'h000};

endpackage

// ==== common/pipeIf.sv ====
/* Stage-boundary bundles. Both carry register outputs only, so every reader
   sees values that change right after a rising clock edge */
interface decodeExIf;
  import cpuPkg::*;

  CtrlWord  ctrl;
  wordT     pc;
  InstrWord instr;
  wordT     operandA;
  wordT     operandB;
  regIndexT destIndex;

  modport source  (output ctrl, pc, instr, operandA, operandB, destIndex);
  modport sink    (input ctrl, pc, instr, operandA, operandB, destIndex);
  modport monitor (input ctrl, destIndex);   // Hazard compare
endinterface

interface exMemIf;
  import cpuPkg::*;

  CtrlWord  ctrl;
  wordT     aluResult;
  logic     aluZero;
  wordT     branchTarget;
  wordT     storeData;
  regIndexT destIndex;

  modport source  (output ctrl, aluResult, aluZero, branchTarget, storeData, destIndex);
  modport sink    (input ctrl, aluResult, aluZero, branchTarget, storeData, destIndex);
  modport monitor (input ctrl, destIndex);
endinterface

// ==== hw/fetch/fetchUnit.sv ====
/* PC and fetch/decode register. Redirect beats stall; resetAddress must be even */
module fetchUnit #(
  parameter cpuPkg::wordT resetAddress = '0
) (
  input  logic             clock,
  input  logic             reset,
  input  cpuPkg::InstrWord instr,
  input  logic             stall,
  input  logic             redirect,
  input  cpuPkg::wordT     redirectTarget,
  output cpuPkg::wordT     imAddress,
  output cpuPkg::InstrWord fetchedInstr,
  output cpuPkg::wordT     fetchedPc
);
  import cpuPkg::*;

  wordT pc;

  assign imAddress = pc;   // Straight from the register

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      pc           <= resetAddress;
      fetchedInstr <= nopInstr;
    end
    else if (redirect)
    begin
      pc           <= redirectTarget;
      fetchedInstr <= nopInstr;   // Squash the wrong-path fetch
    end
    else if (!stall)
    begin
      pc           <= pc + pcStep;
      fetchedInstr <= instr;
    end
  end

  // Only meaningful alongside a valid fetchedInstr
  always_ff @(posedge clock)
  begin
    if (!redirect && !stall)
      fetchedPc <= pc;
  end

  // Branch targets come from execute, so this checks the offset math too
  assert property (@(posedge clock) disable iff (reset) pc[0] == 1'b0)
    else $error("PC became odd: %h", pc);

endmodule

// ==== hw/decode/regFile.sv ====
/* Eight-entry register file. Register 7 reads as zero and ignores writes;
   a writeback in the same cycle is passed through to the read ports */
module regFile (
  input  logic             clock,
  input  logic             reset,
  input  cpuPkg::regIndexT readIndexA,
  input  cpuPkg::regIndexT readIndexB,
  output cpuPkg::wordT     readDataA,
  output cpuPkg::wordT     readDataB,
  input  logic             writeEnable,
  input  cpuPkg::regIndexT writeIndex,
  input  cpuPkg::wordT     writeData
);
  import cpuPkg::*;

  wordT regs [0:6];   // No storage for the zero register

  function automatic wordT readPort(regIndexT index);
    if (index == zeroReg)
      return '0;
    else if (writeEnable && writeIndex == index)
      return writeData;   // Write-through
    else
      return regs[index];
  endfunction

  always_comb
  begin
    readDataA = readPort(readIndexA);
    readDataB = readPort(readIndexB);
  end

  always_ff @(posedge clock)
  begin
    if (writeEnable && writeIndex != zeroReg)
      regs[writeIndex] <= writeData;
  end

  // Writeback data comes from the ALU or the external data memory
  assert property (@(posedge clock) disable iff (reset)
    writeEnable |-> !$isunknown(writeData))
    else $error("Unknown value written to r%0d", writeIndex);

endmodule

// ==== hw/decode/hazardUnit.sv ====
/* Stall generation. RAW stalls last two cycles behind any producer;
   a branch holds fetch for two cycles until it resolves in memory */
module hazardUnit (
  input  logic             clock,
  input  logic             reset,
  input  cpuPkg::InstrWord decodeInstr,
  input  logic             issueBranch,
  decodeExIf.monitor       execMon,
  exMemIf.monitor          memMon,
  output logic             stall
);
  import cpuPkg::*;

  regIndexT   srcA;
  regIndexT   srcB;
  logic       execHit;
  logic       memHit;
  logic [1:0] branchCount;

  function automatic logic readsDest(regIndexT src, regIndexT dest);
    return src != zeroReg && src == dest;
  endfunction

  assign srcA = decodeInstr.fields[2:0];
  assign srcB = decodeInstr.fields[5:3];

  assign execHit = execMon.ctrl.regWrite &&
                   (readsDest(srcA, execMon.destIndex) || readsDest(srcB, execMon.destIndex));
  assign memHit  = memMon.ctrl.regWrite &&
                   (readsDest(srcA, memMon.destIndex) || readsDest(srcB, memMon.destIndex));

  assign stall = execHit || memHit || (branchCount != 2'd0);

  // --------------------
  // Branch shadow
  always_ff @(posedge clock)
  begin
    if (reset)
      branchCount <= 2'd0;
    else if (issueBranch)
      branchCount <= 2'd2;   // Resolves two cycles after issue
    else if (branchCount != 2'd0)
      branchCount <= branchCount - 2'd1;
  end

  // The branch sits in execute/memory while the counter reads one
  assert property (@(posedge clock) disable iff (reset)
    branchCount == 2'd1 |-> (memMon.ctrl.branchCond || memMon.ctrl.branchUncond))
    else $error("Branch counter out of step with execute/memory: %0d", branchCount);

endmodule

// ==== hw/decode/decodeUnit.sv ====
/* Decode stage with the decode/execute register. Stall or redirect loads a bubble;
   reserved opcodes decode as NOP */
module decodeUnit (
  input  logic             clock,
  input  logic             reset,
  input  cpuPkg::InstrWord fetchedInstr,
  input  cpuPkg::wordT     fetchedPc,
  input  logic             redirect,
  input  logic             wbWrite,
  input  cpuPkg::regIndexT wbIndex,
  input  cpuPkg::wordT     wbData,
  decodeExIf.source        toExecute,
  output logic             stall,
  decodeExIf.monitor       execMon,
  exMemIf.monitor          memMon
);
  import cpuPkg::*;

  CtrlWord  decoded;
  regIndexT destIndex;
  wordT     readDataA;
  wordT     readDataB;
  logic     issueBranch;

  regFile regs (
    .clock       (clock),
    .reset       (reset),
    .readIndexA  (fetchedInstr.fields[2:0]),
    .readIndexB  (fetchedInstr.fields[5:3]),
    .readDataA   (readDataA),
    .readDataB   (readDataB),
    .writeEnable (wbWrite),
    .writeIndex  (wbIndex),
    .writeData   (wbData)
  );

  hazardUnit hazards (
    .clock       (clock),
    .reset       (reset),
    .decodeInstr (fetchedInstr),
    .issueBranch (issueBranch),
    .execMon     (execMon),
    .memMon      (memMon),
    .stall       (stall)
  );

  // --------------------
  // Opcode decode
  always_comb
  begin
    decoded = ctrlIdle;
    case (fetchedInstr.op)
      opAdd, opSub, opAnd, opOr:
      begin
        decoded.regWrite = 1'b1;
        decoded.aluOp    = AluOp'({1'b0, fetchedInstr.op[1:0]});   // Low bits pick the op
      end
      opAddi, opSubi, opAndi, opOri:
      begin
        decoded.regWrite = 1'b1;
        decoded.useImm   = 1'b1;
        decoded.aluOp    = AluOp'({1'b0, fetchedInstr.op[1:0]});
      end
      opLd:
      begin
        decoded.regWrite     = 1'b1;
        decoded.memRead      = 1'b1;
        decoded.writeFromMem = 1'b1;
        decoded.useImm       = 1'b1;
        decoded.aluOp        = aluAdd;   // Base plus offset
      end
      opSt:
      begin
        decoded.memWrite = 1'b1;
        decoded.useImm   = 1'b1;
        decoded.aluOp    = aluAdd;
      end
      opCbz:
        decoded.branchCond = 1'b1;       // ALU passes the tested register
      opCbnz:
      begin
        decoded.branchCond      = 1'b1;
        decoded.branchOnNonZero = 1'b1;
      end
      opBu:
        decoded.branchUncond = 1'b1;
      default:
        decoded = ctrlIdle;              // NOP and reserved codes
    endcase
  end

  // R-type writes bits 8:6, everything else bits 5:3
  assign destIndex = (fetchedInstr.op inside {opAdd, opSub, opAnd, opOr}) ?
                     fetchedInstr.fields[8:6] : fetchedInstr.fields[5:3];

  assign issueBranch = (decoded.branchCond || decoded.branchUncond) && !stall && !redirect;

  // --------------------
  // Decode/execute register
  always_ff @(posedge clock)
  begin
    if (reset || stall || redirect)
      toExecute.ctrl <= ctrlIdle;   // Bubble
    else
      toExecute.ctrl <= decoded;
  end

  always_ff @(posedge clock)
  begin
    toExecute.pc        <= fetchedPc;
    toExecute.instr     <= fetchedInstr;
    toExecute.operandA  <= readDataA;
    toExecute.operandB  <= readDataB;
    toExecute.destIndex <= destIndex;
  end

endmodule

// ==== hw/execute/executeUnit.sv ====
/* Execute stage with the execute/memory register. Immediates and branch
   offsets are sign-extended; offsets count instructions, not bytes */
module executeUnit (
  input logic      clock,
  input logic      reset,
  decodeExIf.sink  fromDecode,
  exMemIf.source   toMemory
);
  import cpuPkg::*;

  wordT immExt;
  wordT aluB;
  wordT aluResult;
  wordT condOffset;
  wordT uncondOffset;
  wordT branchTarget;

  assign immExt = {{10{fromDecode.instr.fields[11]}}, fromDecode.instr.fields[11:6]};
  assign aluB   = fromDecode.ctrl.useImm ? immExt : fromDecode.operandB;

  // --------------------
  // ALU
  always_comb
  begin
    case (fromDecode.ctrl.aluOp)
      aluAdd:  aluResult = fromDecode.operandA + aluB;
      aluSub:  aluResult = fromDecode.operandA - aluB;
      aluAnd:  aluResult = fromDecode.operandA & aluB;
      aluOr:   aluResult = fromDecode.operandA | aluB;
      default: aluResult = fromDecode.operandA;   // Pass for CBZ and CBNZ
    endcase
  end

  // Byte offsets from the 9-bit and 12-bit fields
  assign condOffset   = {{6{fromDecode.instr.fields[11]}}, fromDecode.instr.fields[11:3], 1'b0};
  assign uncondOffset = {{3{fromDecode.instr.fields[11]}}, fromDecode.instr.fields[11:0], 1'b0};
  assign branchTarget = fromDecode.pc +
                        (fromDecode.ctrl.branchUncond ? uncondOffset : condOffset);

  // --------------------
  // Execute/memory register
  always_ff @(posedge clock)
  begin
    if (reset)
      toMemory.ctrl <= ctrlIdle;
    else
      toMemory.ctrl <= fromDecode.ctrl;
  end

  always_ff @(posedge clock)
  begin
    toMemory.aluResult    <= aluResult;
    toMemory.aluZero      <= (aluResult == '0);
    toMemory.branchTarget <= branchTarget;
    toMemory.storeData    <= fromDecode.operandB;   // Register at bits 5:3
    toMemory.destIndex    <= fromDecode.destIndex;
  end

endmodule

// ==== hw/memory/memoryStage.sv ====
/* Memory and writeback stage. The external data memory must answer in the same
   cycle; branches resolve here and redirect fetch combinationally */
module memoryStage (
  input  logic             clock,
  input  logic             reset,
  exMemIf.sink             fromExecute,
  output cpuPkg::wordT     memAddress,
  output cpuPkg::wordT     memWriteData,
  output logic             memRead,
  output logic             memWrite,
  input  cpuPkg::wordT     memReadData,
  output logic             redirect,
  output cpuPkg::wordT     redirectTarget,
  output logic             wbWrite,
  output cpuPkg::regIndexT wbIndex,
  output cpuPkg::wordT     wbData
);
  import cpuPkg::*;

  logic wbFromMem;
  wordT wbLoad;
  wordT wbAlu;

  // Data port straight from execute/memory
  assign memAddress   = fromExecute.aluResult;
  assign memWriteData = fromExecute.storeData;
  assign memRead      = fromExecute.ctrl.memRead;
  assign memWrite     = fromExecute.ctrl.memWrite;

  // Taken when zero flag matches the branch sense
  assign redirect = fromExecute.ctrl.branchUncond ||
                    (fromExecute.ctrl.branchCond &&
                     (fromExecute.aluZero != fromExecute.ctrl.branchOnNonZero));
  assign redirectTarget = fromExecute.branchTarget;

  // --------------------
  // Writeback register
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      wbWrite   <= 1'b0;
      wbFromMem <= 1'b0;
    end
    else
    begin
      wbWrite   <= fromExecute.ctrl.regWrite;
      wbFromMem <= fromExecute.ctrl.writeFromMem;
    end
  end

  always_ff @(posedge clock)
  begin
    wbIndex <= fromExecute.destIndex;
    wbLoad  <= memReadData;
    wbAlu   <= fromExecute.aluResult;
  end

  assign wbData = wbFromMem ? wbLoad : wbAlu;

  // Decode must never build a control word with both
  assert property (@(posedge clock) disable iff (reset) !(memRead && memWrite))
    else $error("memRead and memWrite both high at %h", memAddress);

endmodule

// ==== hw/pipelineCpu.sv ====
/* Four-stage 16-bit CPU. Instruction and data memories are external and read
   combinationally; data memory is word addressed by memAddress[7:1] */
module pipelineCpu #(
  parameter cpuPkg::wordT resetAddress = '0
) (
  input  logic             clock,
  input  logic             reset,
  output cpuPkg::wordT     imAddress,
  input  cpuPkg::InstrWord instr,
  output cpuPkg::wordT     memAddress,
  output cpuPkg::wordT     memWriteData,
  output logic             memRead,
  output logic             memWrite,
  input  cpuPkg::wordT     memReadData
);
  import cpuPkg::*;

  InstrWord fetchedInstr;
  wordT     fetchedPc;
  logic     stall;
  logic     redirect;
  wordT     redirectTarget;
  logic     wbWrite;
  regIndexT wbIndex;
  wordT     wbData;

  decodeExIf decodeEx ();
  exMemIf    exMem ();

  fetchUnit #(
    .resetAddress (resetAddress)
  ) fetch (
    .clock          (clock),
    .reset          (reset),
    .instr          (instr),
    .stall          (stall),
    .redirect       (redirect),
    .redirectTarget (redirectTarget),
    .imAddress      (imAddress),
    .fetchedInstr   (fetchedInstr),
    .fetchedPc      (fetchedPc)
  );

  decodeUnit decode (
    .clock        (clock),
    .reset        (reset),
    .fetchedInstr (fetchedInstr),
    .fetchedPc    (fetchedPc),
    .redirect     (redirect),
    .wbWrite      (wbWrite),
    .wbIndex      (wbIndex),
    .wbData       (wbData),
    .toExecute    (decodeEx),
    .stall        (stall),
    .execMon      (decodeEx),
    .memMon       (exMem)
  );

  executeUnit execute (
    .clock      (clock),
    .reset      (reset),
    .fromDecode (decodeEx),
    .toMemory   (exMem)
  );

  memoryStage memory (
    .clock          (clock),
    .reset          (reset),
    .fromExecute    (exMem),
    .memAddress     (memAddress),
    .memWriteData   (memWriteData),
    .memRead        (memRead),
    .memWrite       (memWrite),
    .memReadData    (memReadData),
    .redirect       (redirect),
    .redirectTarget (redirectTarget),
    .wbWrite        (wbWrite),
    .wbIndex        (wbIndex),
    .wbData         (wbData)
  );

endmodule

// ==== verif/cpuTbProgram.svh ====
/* Program and expected stores for cpuTb. Include inside cpuTb after dataMem is declared
   and call buildTables once dataMem holds its preload, before any store can land */
`ifndef cpuTbProgramSvh
`define cpuTbProgramSvh

localparam int programLength = 40;
localparam int storeCount    = 12;

InstrWord programRom [0:programLength-1];
wordT     expAddress [0:storeCount-1];
wordT     expData    [0:storeCount-1];
string    expName    [0:storeCount-1];

// --------------------
// Field packing

// R-type with rd at 8:6, rs2 at 5:3 and rs1 at 2:0
function automatic InstrWord encodeR(Opcode code, int rd, int rs1, int rs2);
  return '{op: code, fields: {3'b000, rd[2:0], rs2[2:0], rs1[2:0]}};
endfunction

// I-type, LD and ST put imm at 11:6, rd or store data at 5:3 and rs or base at 2:0
function automatic InstrWord encodeI(Opcode code, int rd, int rs, int imm);
  return '{op: code, fields: {imm[5:0], rd[2:0], rs[2:0]}};
endfunction

function automatic InstrWord encodeCb(Opcode code, int rs, int offset);
  return '{op: code, fields: {offset[8:0], rs[2:0]}};   // Offset in instructions
endfunction

function automatic InstrWord encodeB(int offset);
  return '{op: opBu, fields: offset[11:0]};
endfunction

// Preloaded word for a byte address through bits 7:1
function automatic wordT loadedWord(wordT address);
  return dataMem[address[7:1]];
endfunction

task automatic expectStore(int index, string name, wordT address, wordT data);
  expName[index]    = name;
  expAddress[index] = address;
  expData[index]    = data;
endtask

// --------------------
// Tables
task automatic buildTables();
  programRom[0]  = encodeI(opAddi, 1, 7, 25);     // r1 = 0x0019
  programRom[1]  = encodeI(opAddi, 2, 7, -7);     // r2 = 0xFFF9
  programRom[2]  = encodeI(opSubi, 3, 1, 30);     // r3 = 25 - 30 = 0xFFFB
  programRom[3]  = encodeI(opAndi, 4, 2, 28);     // r4 = 0xFFF9 & 0x001C = 0x0018
  programRom[4]  = encodeI(opOri, 5, 1, -16);     // r5 = 0x0019 | 0xFFF0 = 0xFFF9
  programRom[5]  = encodeI(opSt, 3, 7, 0);
  programRom[6]  = encodeI(opSt, 4, 7, 2);
  programRom[7]  = encodeI(opSt, 5, 7, 4);
  programRom[8]  = encodeR(opAdd, 6, 1, 2);       // r6 = 25 + (-7) = 0x0012
  programRom[9]  = encodeR(opSub, 0, 1, 2);       // r0 = 25 - (-7) = 0x0020
  programRom[10] = encodeR(opAnd, 3, 1, 2);       // r3 = 0x0019
  programRom[11] = encodeR(opOr, 4, 3, 6);        // r4 = 0x0019 | 0x0012 = 0x001B
  programRom[12] = encodeI(opSt, 6, 7, 6);
  programRom[13] = encodeI(opSt, 0, 7, 8);
  programRom[14] = encodeI(opSt, 3, 7, 10);
  programRom[15] = encodeI(opSt, 4, 7, 12);
  // Loads from the high words each feed the next instruction
  programRom[16] = encodeI(opLd, 1, 7, -20);      // Address 0xFFEC
  programRom[17] = encodeR(opAdd, 2, 1, 6);
  programRom[18] = encodeI(opSt, 2, 7, 14);
  programRom[19] = encodeI(opLd, 3, 7, -30);      // Address 0xFFE2
  programRom[20] = encodeI(opSubi, 4, 3, 9);
  programRom[21] = encodeI(opSt, 4, 7, 16);
  // Chain on r5 through 3, 6, 16, 0xFFF0, 0xFFF5 and 0x0015
  programRom[22] = encodeI(opAddi, 5, 7, 3);
  programRom[23] = encodeR(opAdd, 5, 5, 5);
  programRom[24] = encodeI(opAddi, 5, 5, 10);
  programRom[25] = encodeR(opSub, 5, 5, 0);
  programRom[26] = encodeI(opOri, 5, 5, 5);
  programRom[27] = encodeI(opAndi, 5, 5, 31);
  programRom[28] = encodeI(opSt, 5, 7, 18);
  // Branch tests with marker stores to 30 and 28
  programRom[29] = encodeCb(opCbz, 7, 2);         // Taken to 31
  programRom[30] = encodeI(opSt, 6, 7, 30);
  programRom[31] = encodeCb(opCbz, 6, 2);         // Not taken as r6 is non-zero
  programRom[32] = encodeI(opSt, 6, 7, 20);
  programRom[33] = encodeCb(opCbnz, 0, 2);        // Taken to 35
  programRom[34] = encodeI(opSt, 0, 7, 30);
  programRom[35] = encodeB(3);                    // To 38
  programRom[36] = encodeI(opSt, 0, 7, 30);
  programRom[37] = encodeI(opSt, 6, 7, 28);
  programRom[38] = encodeI(opAddi, 7, 7, 5);      // Dropped by r7
  programRom[39] = encodeI(opSt, 7, 7, 22);

  expectStore(0, "subi", 16'h0000, 16'hFFFB);
  expectStore(1, "andi", 16'h0002, 16'h0018);
  expectStore(2, "ori", 16'h0004, 16'hFFF9);
  expectStore(3, "add", 16'h0006, 16'h0012);
  expectStore(4, "sub", 16'h0008, 16'h0020);
  expectStore(5, "and", 16'h000A, 16'h0019);
  expectStore(6, "or", 16'h000C, 16'h001B);
  expectStore(7, "ld then add", 16'h000E, loadedWord(16'hFFEC) + 16'h0012);
  expectStore(8, "ld then subi", 16'h0010, loadedWord(16'hFFE2) - 16'h0009);
  expectStore(9, "dependency chain", 16'h0012, 16'h0015);
  expectStore(10, "cbz not taken", 16'h0014, 16'h0012);
  expectStore(11, "zero register", 16'h0016, 16'h0000);
endtask

`endif

// ==== verif/cpuTb.sv ====
/* Testbench for pipelineCpu. Stores are checked in program order; a store that
   should have been skipped shows up as a wrong address */
module cpuTb;
  timeunit 1ns;
  timeprecision 100ps;
  import cpuPkg::*;

  logic     clock;
  logic     reset;
  wordT     imAddress;
  InstrWord instr;
  wordT     memAddress;
  wordT     memWriteData;
  logic     memRead;
  logic     memWrite;
  wordT     memReadData;

  wordT   dataMem [0:127];   // Word addressed by memAddress[7:1]
  integer seed;
  int     romIndex;

  `include "cpuTbProgram.svh"

  localparam int watchdogNs = programLength * 4 * 8 * 2;

  pipelineCpu #(
    .resetAddress (16'h0000)
  ) uut (
    .clock        (clock),
    .reset        (reset),
    .imAddress    (imAddress),
    .instr        (instr),
    .memAddress   (memAddress),
    .memWriteData (memWriteData),
    .memRead      (memRead),
    .memWrite     (memWrite),
    .memReadData  (memReadData)
  );

  always #4 clock = ~clock;   // 8 ns period

  // --------------------
  // Memory models
  always @(posedge clock)
  begin
    if (memWrite === 1'b1)
      dataMem[memAddress[7:1]] <= memWriteData;
  end

  // Both reads follow the new addresses a little after the edge
  always @(posedge clock)
  begin
    #1;
    memReadData = dataMem[memAddress[7:1]];
    romIndex    = int'(imAddress[15:1]);
    instr       = (romIndex < programLength) ? programRom[romIndex] : nopInstr;
  end

  // --------------------
  // Checks
  task automatic stopOnFailure(input string reason);
    $display("%s", reason);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic checkWord(input string name, input wordT expected, input wordT actual);
    if (actual !== expected)
      stopOnFailure($sformatf("[ERROR] %s: expected %h, actual %h", name, expected, actual));
  endtask

  task automatic checkFlag(input string name, input logic expected, input logic actual);
    if (actual !== expected)
      stopOnFailure($sformatf("[ERROR] %s: expected %b, actual %b", name, expected, actual));
  endtask

  initial
  begin
    clock       = 1'b0;
    reset       = 1'b1;
    instr       = nopInstr;
    memReadData = '0;
    seed        = 32'h9bde0ed3;
    for (int i = 0; i < 128; i++)
      dataMem[i] = wordT'($random(seed));
    buildTables();

    @(negedge clock);   // First edge in reset has passed
    checkWord("reset imAddress", 16'h0000, imAddress);
    checkFlag("reset memRead", 1'b0, memRead);
    checkFlag("reset memWrite", 1'b0, memWrite);
    @(posedge clock);
    #1 reset = 1'b0;
    @(negedge clock);
    checkWord("after reset imAddress", 16'h0000, imAddress);
    checkFlag("after reset memRead", 1'b0, memRead);
    checkFlag("after reset memWrite", 1'b0, memWrite);

    // One table entry per store in program order
    for (int i = 0; i < storeCount; i++)
    begin
      @(negedge clock);
      while (memWrite !== 1'b1)
        @(negedge clock);
      checkWord({expName[i], " address"}, expAddress[i], memAddress);
      checkWord({expName[i], " data"}, expData[i], memWriteData);
    end

    repeat (10)
    begin
      @(negedge clock);
      checkFlag("no store past the table", 1'b0, memWrite);
    end

    $display("All tests passed");
    $finish;
  end

  // --------------------
  // Watchdog
  initial
  begin
    #(watchdogNs);
    stopOnFailure("Timeout: the program did not finish its stores in time");
  end

endmodule

// ==== verilog.f ====
+incdir+verif
common/cpuPkg.sv
common/pipeIf.sv
hw/fetch/fetchUnit.sv
hw/decode/regFile.sv
hw/decode/hazardUnit.sv
hw/decode/decodeUnit.sv
hw/execute/executeUnit.sv
hw/memory/memoryStage.sv
hw/pipelineCpu.sv
verif/cpuTb.sv
